// File: logic/gamePkg.sv
`default_nettype none

package gamePkg;

    // every coordinate and position on the reduced raster is this wide
    localparam int PIXEL_WIDTH = 11;

    // visible area walked by the scanner, one pixel per clock
    localparam int SCREEN_WIDTH = 160;
    localparam int SCREEN_HEIGHT = 120;

    // fixed point scale, must stay a power of two
    // positions are kept in 1/64 pixel steps and divided down at the outputs
    localparam int FIXED_POINT_MULTIPLIER = 64;

    // missile speed per frame in 1/64 pixel units, negative is upward
    localparam int MISSILE_X_SPEED = 0;
    localparam int MISSILE_Y_SPEED = -256;
    // shifts the missile so it leaves from the middle of the ship
    localparam int MISSILE_X_OFFSET = 6;

    // ship geometry and motion
    localparam int SHIP_WIDTH = 16;
    localparam int SHIP_HEIGHT = 8;
    localparam int SHIP_Y = 100;
    localparam int SHIP_SPEED = 2;
    localparam int SHIP_START_X = 72;

    localparam int MISSILE_WIDTH = 4;
    localparam int MISSILE_HEIGHT = 8;

    // the target never moves
    localparam int TARGET_X = 70;
    localparam int TARGET_Y = 20;
    localparam int TARGET_WIDTH = 20;
    localparam int TARGET_HEIGHT = 12;

    // missile against target sits in this bit of the collision vector
    localparam int HIT_BIT = 0;
    localparam int HIT_COUNT_WIDTH = 8;

    // scan position, never negative
    typedef logic [PIXEL_WIDTH-1:0] pixelT;
    // object corner, negative once an object slides past the top or left edge
    typedef logic signed [PIXEL_WIDTH-1:0] coordT;
    typedef logic [HIT_COUNT_WIDTH-1:0] hitCountT;

endpackage

`default_nettype wire

// File: logic/frameScanner.sv
`timescale 1ns/1ps
`default_nettype none

module frameScanner (
    input  wire logic          clk,
    input  wire logic          resetN,
    output gamePkg::pixelT     pixelX,
    output gamePkg::pixelT     pixelY,
    output logic               startOfFrame
);

    logic lastColumn;
    logic lastRow;

    // end of a line and end of the screen
    assign lastColumn = (int'(pixelX) == gamePkg::SCREEN_WIDTH - 1);
    assign lastRow = (int'(pixelY) == gamePkg::SCREEN_HEIGHT - 1);

    // raster order, column moves every clock and the row moves on column wrap
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixelX <= '0;
            pixelY <= '0;
        end else begin
            if (lastColumn) begin
                pixelX <= '0;
                if (lastRow) begin
                    pixelY <= '0;
                end else begin
                    pixelY <= pixelY + 1'b1;
                end
            end else begin
                pixelX <= pixelX + 1'b1;
            end
        end
    end

    // registered together with the wrap so the pulse lines up with pixel (0,0)
    // the reset state is (0,0) too but no pulse is given there
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            startOfFrame <= 1'b0;
        end else begin
            startOfFrame <= lastColumn && lastRow;
        end
    end

endmodule

`default_nettype wire

// File: logic/shipMovement.sv
`timescale 1ns/1ps
`default_nettype none

module shipMovement (
    input  wire logic       clk,
    input  wire logic       resetN,
    input  wire logic       startOfFrame,
    input  wire logic       moveLeft,
    input  wire logic       moveRight,
    output gamePkg::coordT  shipX
);

    // rightmost column the ship corner may take and still be fully visible
    localparam int MAX_X = gamePkg::SCREEN_WIDTH - gamePkg::SHIP_WIDTH;

    int currentX;
    int nextX;

    // key rule for one frame, worked in int so the clamp sees negatives
    always_comb begin
        currentX = int'(shipX);
        nextX = currentX;
        // both keys together cancel out, just like no key at all
        if (moveLeft && !moveRight) begin
            nextX = currentX - gamePkg::SHIP_SPEED;
        end else if (moveRight && !moveLeft) begin
            nextX = currentX + gamePkg::SHIP_SPEED;
        end
        // keep the whole ship on screen
        if (nextX < 0) begin
            nextX = 0;
        end else if (nextX > MAX_X) begin
            nextX = MAX_X;
        end
    end

    // the ship only moves once per frame, on the start of frame edge
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            shipX <= gamePkg::coordT'(gamePkg::SHIP_START_X);
        end else if (startOfFrame) begin
            shipX <= gamePkg::coordT'(nextX);
        end
    end

endmodule

`default_nettype wire

// File: logic/missileMovement.sv
`timescale 1ns/1ps
`default_nettype none

module missileMovement (
    input  wire logic           clk,
    input  wire logic           resetN,
    // one cycle pulse at the first pixel of every frame
    input  wire logic           startOfFrame,
    input  wire logic           shotKeyIsPress,
    input  wire logic [3:0]     collision,
    input  gamePkg::coordT      spaceShipX,
    input  gamePkg::coordT      spaceShipY,
    // top left corner of the missile, negative after it leaves through the top
    output gamePkg::coordT      topLeftX,
    output gamePkg::coordT      topLeftY
);

    // shot requested somewhere in the current frame
    logic shotFired;

    // corner in 1/64 pixel units so slow speeds still make progress
    int topLeftXFixed;
    int topLeftYFixed;

    // later branches win over earlier ones within the same cycle
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            shotFired <= 1'b0;
            topLeftXFixed <= 0;
            topLeftYFixed <= 0;
        end else begin
            // remember the key until the frame boundary
            if (shotKeyIsPress) begin
                shotFired <= 1'b1;
            end
            // a hit parks the missile at the origin and drops any pending shot
            if (collision[gamePkg::HIT_BIT]) begin
                topLeftXFixed <= 0;
                topLeftYFixed <= 0;
                shotFired <= 1'b0;
            end
            if (startOfFrame) begin
                shotFired <= 1'b0;
                if (shotFired) begin
                    // launch from the ship corner
                    topLeftXFixed <= int'(spaceShipX) * gamePkg::FIXED_POINT_MULTIPLIER;
                    topLeftYFixed <= int'(spaceShipY) * gamePkg::FIXED_POINT_MULTIPLIER;
                end else begin
                    // otherwise keep flying at the fixed speed
                    topLeftXFixed <= topLeftXFixed + gamePkg::MISSILE_X_SPEED;
                    topLeftYFixed <= topLeftYFixed + gamePkg::MISSILE_Y_SPEED;
                end
            end
        end
    end

    // back to whole pixels, signed division truncates toward zero
    assign topLeftX = gamePkg::coordT'(topLeftXFixed / gamePkg::FIXED_POINT_MULTIPLIER
                                       + gamePkg::MISSILE_X_OFFSET);
    assign topLeftY = gamePkg::coordT'(topLeftYFixed / gamePkg::FIXED_POINT_MULTIPLIER);

endmodule

`default_nettype wire

// File: logic/squareObject.sv
`timescale 1ns/1ps
`default_nettype none

module squareObject #(
    parameter int objectWidth = 16,
    parameter int objectHeight = 16
) (
    input  gamePkg::pixelT  pixelX,
    input  gamePkg::pixelT  pixelY,
    // corner may sit off screen, so it is signed
    input  gamePkg::coordT  topLeftX,
    input  gamePkg::coordT  topLeftY,
    output logic            drawRequest
);

    // pixel zero extends and the corner sign extends into 32 bits
    int pixelXInt;
    int pixelYInt;
    int leftEdge;
    int topEdge;
    logic insideX;
    logic insideY;

    assign pixelXInt = int'(pixelX);
    assign pixelYInt = int'(pixelY);
    assign leftEdge = int'(topLeftX);
    assign topEdge = int'(topLeftY);

    // inclusive on the corner side and exclusive on the far side
    // a rectangle hanging over the edge just loses its hidden rows and columns
    always_comb begin
        insideX = (pixelXInt >= leftEdge) && (pixelXInt < leftEdge + objectWidth);
        insideY = (pixelYInt >= topEdge) && (pixelYInt < topEdge + objectHeight);
    end

    // purely combinational, follows the scan with no delay
    assign drawRequest = insideX && insideY;

endmodule

`default_nettype wire

// File: logic/hitDetector.sv
`timescale 1ns/1ps
`default_nettype none

module hitDetector (
    input  wire logic           clk,
    input  wire logic           resetN,
    input  wire logic           startOfFrame,
    input  wire logic           missileDraw,
    input  wire logic           targetDraw,
    output logic [3:0]          collision,
    output gamePkg::hitCountT   hitCount
);

    // set once this frame has already reported a hit
    logic hitSeen;
    logic overlap;
    logic newHit;
    logic hitPulse;

    // both objects claim the same pixel
    assign overlap = missileDraw && targetDraw;

    // the start of frame cycle belongs to the new frame, so it is armed there
    assign newHit = overlap && (startOfFrame || !hitSeen);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hitSeen <= 1'b0;
            hitPulse <= 1'b0;
            hitCount <= '0;
        end else begin
            // re-arm at the frame boundary unless that very pixel overlaps
            if (startOfFrame) begin
                hitSeen <= overlap;
            end else if (overlap) begin
                hitSeen <= 1'b1;
            end
            // one cycle wide pulse, counter moves on the same edge
            hitPulse <= newHit;
            if (newHit) begin
                // wraps after 255 hits
                hitCount <= hitCount + 1'b1;
            end
        end
    end

    // only the missile against target bit is ever raised
    assign collision = 4'(hitPulse) << gamePkg::HIT_BIT;

endmodule

`default_nettype wire

// File: logic/gameTop.sv
`timescale 1ns/1ps
`default_nettype none

module gameTop (
    input  wire logic           clk,
    input  wire logic           resetN,
    // key levels, sampled once per frame
    input  wire logic           moveLeft,
    input  wire logic           moveRight,
    input  wire logic           shotKeyIsPress,
    output logic                startOfFrame,
    output gamePkg::pixelT      pixelX,
    output gamePkg::pixelT      pixelY,
    output gamePkg::coordT      shipX,
    output gamePkg::coordT      missileX,
    output gamePkg::coordT      missileY,
    output logic                shipDraw,
    output logic                missileDraw,
    output logic                targetDraw,
    output gamePkg::hitCountT   hitCount
);

    // collision vector fed back from the detector into the missile
    logic [3:0] collision;

    // scan position and frame pulse shared by everyone
    frameScanner scanner (
        .clk          (clk),
        .resetN       (resetN),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .startOfFrame (startOfFrame)
    );

    shipMovement ship (
        .clk          (clk),
        .resetN       (resetN),
        .startOfFrame (startOfFrame),
        .moveLeft     (moveLeft),
        .moveRight    (moveRight),
        .shipX        (shipX)
    );

    // the ship stays on one row so its Y comes straight from the package
    missileMovement missile (
        .clk            (clk),
        .resetN         (resetN),
        .startOfFrame   (startOfFrame),
        .shotKeyIsPress (shotKeyIsPress),
        .collision      (collision),
        .spaceShipX     (shipX),
        .spaceShipY     (gamePkg::coordT'(gamePkg::SHIP_Y)),
        .topLeftX       (missileX),
        .topLeftY       (missileY)
    );

    // one draw request per object for the pixel being scanned
    squareObject #(
        .objectWidth  (gamePkg::SHIP_WIDTH),
        .objectHeight (gamePkg::SHIP_HEIGHT)
    ) shipSquare (
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .topLeftX    (shipX),
        .topLeftY    (gamePkg::coordT'(gamePkg::SHIP_Y)),
        .drawRequest (shipDraw)
    );

    squareObject #(
        .objectWidth  (gamePkg::MISSILE_WIDTH),
        .objectHeight (gamePkg::MISSILE_HEIGHT)
    ) missileSquare (
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .topLeftX    (missileX),
        .topLeftY    (missileY),
        .drawRequest (missileDraw)
    );

    // target corner is fixed
    squareObject #(
        .objectWidth  (gamePkg::TARGET_WIDTH),
        .objectHeight (gamePkg::TARGET_HEIGHT)
    ) targetSquare (
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .topLeftX    (gamePkg::coordT'(gamePkg::TARGET_X)),
        .topLeftY    (gamePkg::coordT'(gamePkg::TARGET_Y)),
        .drawRequest (targetDraw)
    );

    // first missile and target overlap of each frame becomes a hit
    hitDetector detector (
        .clk          (clk),
        .resetN       (resetN),
        .startOfFrame (startOfFrame),
        .missileDraw  (missileDraw),
        .targetDraw   (targetDraw),
        .collision    (collision),
        .hitCount     (hitCount)
    );

endmodule

`default_nettype wire

// File: sim/gameTop_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module gameTopAssertions (
    input wire logic              clk,
    input wire logic              resetN,
    input wire logic              startOfFrame,
    input wire logic              missileDraw,
    input wire logic              targetDraw,
    input wire logic [3:0]        collision,
    input gamePkg::hitCountT      hitCount
);

    // the frame pulse is a single cycle wide
    sofSingleCycle: assert property (
        @(posedge clk) disable iff (!resetN)
        startOfFrame |=> !startOfFrame
    ) else $error("startOfFrame high on two cycles in a row");

    // the hit bit is registered from an overlap on the previous cycle
    hitFollowsOverlap: assert property (
        @(posedge clk) disable iff (!resetN)
        collision[gamePkg::HIT_BIT] |-> $past(missileDraw && targetDraw)
    ) else $error("collision pulse without a preceding overlap");

    // the counter steps by one, and only alongside a hit pulse
    countStepsWithHit: assert property (
        @(posedge clk) disable iff (!resetN)
        (hitCount != $past(hitCount)) |->
            (hitCount == gamePkg::hitCountT'($past(hitCount) + 1'b1))
            && collision[gamePkg::HIT_BIT]
    ) else $error("hitCount changed without a single hit");

endmodule

bind gameTop gameTopAssertions checker0 (
    .clk          (clk),
    .resetN       (resetN),
    .startOfFrame (startOfFrame),
    .missileDraw  (missileDraw),
    .targetDraw   (targetDraw),
    .collision    (collision),
    .hitCount     (hitCount)
);

`default_nettype wire

// File: sim/gameTb.sv
`timescale 1ns/1ps
`default_nettype none

module gameTb;

    localparam int FRAME_CYCLES = gamePkg::SCREEN_WIDTH * gamePkg::SCREEN_HEIGHT;
    localparam int WAIT_LIMIT = 20000;
    localparam int FRAME_COUNT = 130;
    // the shot key is held for ten pixels of the last row
    localparam int SHOT_START = (gamePkg::SCREEN_HEIGHT - 1) * gamePkg::SCREEN_WIDTH + 10;
    localparam int SHOT_END = SHOT_START + 10;

    logic clk;
    logic resetN;
    logic moveLeft;
    logic moveRight;
    logic shotKeyIsPress;
    logic startOfFrame;
    gamePkg::pixelT pixelX;
    gamePkg::pixelT pixelY;
    gamePkg::coordT shipX;
    gamePkg::coordT missileX;
    gamePkg::coordT missileY;
    logic shipDraw;
    logic missileDraw;
    logic targetDraw;
    gamePkg::hitCountT hitCount;

    logic [31:0] lfsrState;
    int errorCount;
    int timeoutCount;

    // frame level model of the game state
    int modelShipX;
    int modelFixedX;
    int modelFixedY;
    int modelHits;
    logic modelShotPending;
    logic modelLeft;
    logic modelRight;

    gameTop dut0 (
        .clk            (clk),
        .resetN         (resetN),
        .moveLeft       (moveLeft),
        .moveRight      (moveRight),
        .shotKeyIsPress (shotKeyIsPress),
        .startOfFrame   (startOfFrame),
        .pixelX         (pixelX),
        .pixelY         (pixelY),
        .shipX          (shipX),
        .missileX       (missileX),
        .missileY       (missileY),
        .shipDraw       (shipDraw),
        .missileDraw    (missileDraw),
        .targetDraw     (targetDraw),
        .hitCount       (hitCount)
    );

    always #50 clk = ~clk;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic int randomBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    // fixed point back to pixels, rounding toward zero for both signs
    function automatic int toPixel(input int fixedValue);
        if (fixedValue < 0) begin
            return -((-fixedValue) / gamePkg::FIXED_POINT_MULTIPLIER);
        end
        return fixedValue / gamePkg::FIXED_POINT_MULTIPLIER;
    endfunction

    function automatic logic insideRect(input int px, input int py, input int x, input int y,
                                        input int w, input int h);
        return (px >= x) && (px < x + w) && (py >= y) && (py < y + h);
    endfunction

    function automatic int maxOf(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    function automatic int minOf(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    task automatic checkPosition(input string what, input gamePkg::coordT actual,
                                 input gamePkg::coordT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic checkPixel(input string what, input gamePkg::pixelT actual,
                              input gamePkg::pixelT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic checkCount(input string what, input gamePkg::hitCountT actual,
                              input gamePkg::hitCountT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic checkDraw(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // returns on the falling edge inside the start of frame cycle
    task automatic waitFrameStart();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!startOfFrame && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!startOfFrame) begin
            timeoutCount++;
            $display("timeout: no start of frame pulse within %0d cycles", WAIT_LIMIT);
        end
    endtask

    initial begin
        int missileOutX;
        int missileOutY;
        int hitIndex;
        int sampleCycle;
        int px;
        int py;
        int ix0;
        int ix1;
        int iy0;
        int iy1;
        logic frameHit;
        logic pressNow;
        logic expectMissile;

        lfsrState = 32'h4da5;
        errorCount = 0;
        timeoutCount = 0;
        clk = 1'b0;
        resetN = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        shotKeyIsPress = 1'b0;
        modelShipX = gamePkg::SHIP_START_X;
        modelFixedX = 0;
        modelFixedY = 0;
        modelHits = 0;
        modelShotPending = 1'b0;
        modelLeft = 1'b0;
        modelRight = 1'b0;

        repeat (4) @(posedge clk);
        resetN <= 1'b1;
        @(negedge clk);
        checkPosition("reset shipX", shipX, gamePkg::coordT'(gamePkg::SHIP_START_X));
        checkPosition("reset missileX", missileX, gamePkg::coordT'(gamePkg::MISSILE_X_OFFSET));
        checkPosition("reset missileY", missileY, gamePkg::coordT'(0));
        checkCount("reset hitCount", hitCount, gamePkg::hitCountT'(0));
        checkDraw("reset startOfFrame", startOfFrame, 1'b0);

        for (int frame = 0; frame < FRAME_COUNT; frame++) begin
            waitFrameStart();
            if (timeoutCount != 0) begin
                break;
            end
            // count seen at the boundary covers every hit of the frame just ended
            checkCount("hitCount", hitCount, gamePkg::hitCountT'(modelHits));

            // the start of frame edge, where ship and missile move
            @(posedge clk);
            if (modelShotPending) begin
                modelFixedX = modelShipX * gamePkg::FIXED_POINT_MULTIPLIER;
                modelFixedY = gamePkg::SHIP_Y * gamePkg::FIXED_POINT_MULTIPLIER;
            end else begin
                modelFixedX = modelFixedX + gamePkg::MISSILE_X_SPEED;
                modelFixedY = modelFixedY + gamePkg::MISSILE_Y_SPEED;
            end
            modelShotPending = 1'b0;
            if (modelLeft && !modelRight) begin
                modelShipX = maxOf(modelShipX - gamePkg::SHIP_SPEED, 0);
            end else if (modelRight && !modelLeft) begin
                modelShipX = minOf(modelShipX + gamePkg::SHIP_SPEED,
                                   gamePkg::SCREEN_WIDTH - gamePkg::SHIP_WIDTH);
            end

            // long one key runs push the ship into both edges, then free play
            if (frame < 40) begin
                modelLeft = 1'b1;
                modelRight = 1'b0;
            end else if (frame < 120) begin
                modelLeft = 1'b0;
                modelRight = 1'b1;
            end else begin
                modelLeft = logic'(randomBits(1));
                modelRight = logic'(randomBits(1));
            end
            moveLeft <= modelLeft;
            moveRight <= modelRight;

            missileOutX = toPixel(modelFixedX) + gamePkg::MISSILE_X_OFFSET;
            missileOutY = toPixel(modelFixedY);

            // overlap of missile, target and the visible screen
            ix0 = maxOf(maxOf(missileOutX, gamePkg::TARGET_X), 0);
            ix1 = minOf(minOf(missileOutX + gamePkg::MISSILE_WIDTH,
                              gamePkg::TARGET_X + gamePkg::TARGET_WIDTH), gamePkg::SCREEN_WIDTH);
            iy0 = maxOf(maxOf(missileOutY, gamePkg::TARGET_Y), 0);
            iy1 = minOf(minOf(missileOutY + gamePkg::MISSILE_HEIGHT,
                              gamePkg::TARGET_Y + gamePkg::TARGET_HEIGHT), gamePkg::SCREEN_HEIGHT);
            frameHit = (ix0 < ix1) && (iy0 < iy1);
            // scan reaches the top left overlap pixel first
            hitIndex = iy0 * gamePkg::SCREEN_WIDTH + ix0;
            if (frameHit) begin
                modelHits = (modelHits + 1) % 256;
                modelFixedX = 0;
                modelFixedY = 0;
            end

            // fire only once the last missile has gone, so shots can reach the target
            pressNow = (missileOutY < 0) && logic'(randomBits(1));
            modelShotPending = pressNow;
            sampleCycle = 1 + (randomBits(15) % (FRAME_CYCLES - 1));

            for (int c = 1; c < FRAME_CYCLES; c++) begin
                @(negedge clk);
                if (c == 1) begin
                    checkPosition("shipX", shipX, gamePkg::coordT'(modelShipX));
                    checkPosition("missileX", missileX, gamePkg::coordT'(missileOutX));
                    checkPosition("missileY", missileY, gamePkg::coordT'(missileOutY));
                end
                if (c == sampleCycle) begin
                    px = c % gamePkg::SCREEN_WIDTH;
                    py = c / gamePkg::SCREEN_WIDTH;
                    checkPixel("pixelX", pixelX, gamePkg::pixelT'(px));
                    checkPixel("pixelY", pixelY, gamePkg::pixelT'(py));
                    // the parked missile shows two cycles after the overlap
                    if (frameHit && c >= hitIndex + 2) begin
                        expectMissile = insideRect(px, py, gamePkg::MISSILE_X_OFFSET, 0,
                                                   gamePkg::MISSILE_WIDTH,
                                                   gamePkg::MISSILE_HEIGHT);
                    end else begin
                        expectMissile = insideRect(px, py, missileOutX, missileOutY,
                                                   gamePkg::MISSILE_WIDTH,
                                                   gamePkg::MISSILE_HEIGHT);
                    end
                    checkDraw("shipDraw", shipDraw,
                              insideRect(px, py, modelShipX, gamePkg::SHIP_Y,
                                         gamePkg::SHIP_WIDTH, gamePkg::SHIP_HEIGHT));
                    checkDraw("missileDraw", missileDraw, expectMissile);
                    checkDraw("targetDraw", targetDraw,
                              insideRect(px, py, gamePkg::TARGET_X, gamePkg::TARGET_Y,
                                         gamePkg::TARGET_WIDTH, gamePkg::TARGET_HEIGHT));
                end
                @(posedge clk);
                if (c + 1 == SHOT_START) begin
                    shotKeyIsPress <= pressNow;
                end else if (c + 1 == SHOT_END) begin
                    shotKeyIsPress <= 1'b0;
                end
            end
        end

        $display("checks done: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/gamePkg.sv
logic/frameScanner.sv
logic/shipMovement.sv
logic/missileMovement.sv
logic/squareObject.sv
logic/hitDetector.sv
logic/gameTop.sv
sim/gameTop_assertions.sv
sim/gameTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module gameTb -Mdir obj_dir \
    && ./obj_dir/VgameTb | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
